//--- hdl/fifo_dc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Geometry of the dual-clock width-converting FIFO
// Both depths must be powers of two, since the pointers
// wrap naturally with one extra bit
// Write words split into RATIO read words, lower half first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fifo_dc_pkg;

// Write side
localparam int I_WIDTH = 32;
localparam int I_DEPTH = 16;

// Read side
localparam int O_WIDTH = 16;
localparam int O_DEPTH = I_DEPTH * I_WIDTH / O_WIDTH;  // Same storage seen in narrow words

// Read words per write word
localparam int RATIO = O_DEPTH / I_DEPTH;

// Address widths
localparam int I_AW = $clog2(I_DEPTH);
localparam int O_AW = $clog2(O_DEPTH);

// Pointer widths carry one wrap bit above the address
localparam int I_PW = I_AW + 1;
localparam int O_PW = O_AW + 1;

endpackage

//--- hdl/fifo_ram_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM ports shared by the FIFO controllers and storage
// Write signals live in the write clock domain and read
// signals in the read clock domain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

interface fifo_ram_if;

logic                             wr_en;
logic [fifo_dc_pkg::I_AW-1:0]     wr_addr;
logic [fifo_dc_pkg::I_WIDTH-1:0]  wr_data;

logic                             rd_en;
logic [fifo_dc_pkg::O_AW-1:0]     rd_addr;
logic [fifo_dc_pkg::O_WIDTH-1:0]  rd_data;  // Registered inside the RAM

modport wr_mp (
    output wr_en,
    output wr_addr,
    output wr_data
);

modport rd_mp (
    output rd_en,
    output rd_addr
);

modport ram_mp (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
);

endinterface

//--- hdl/ptr_cdc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Moves a binary FIFO pointer into another clock domain
// The source pointer may only step by one per source clock
// Output lags by one source and two destination clocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module ptr_cdc #(
    parameter int PW = fifo_dc_pkg::I_PW
) (
    input  logic          src_clk_i,
    input  logic          src_rst_n_i,
    input  logic [PW-1:0] src_ptr_i,

    input  logic          dst_clk_i,
    input  logic          dst_rst_n_i,
    output logic [PW-1:0] dst_ptr_o
);

logic [PW-1:0] src_gray_q;
logic [PW-1:0] sync_q1;
logic [PW-1:0] sync_q2;

// Gray code is registered so only one bit toggles on the crossing path
always_ff @(posedge src_clk_i or negedge src_rst_n_i) begin
    if (!src_rst_n_i) begin
        src_gray_q <= '0;
    end else begin
        src_gray_q <= src_ptr_i ^ (src_ptr_i >> 1);
    end
end

always_ff @(posedge dst_clk_i or negedge dst_rst_n_i) begin
    if (!dst_rst_n_i) begin
        sync_q1 <= '0;
        sync_q2 <= '0;
    end else begin
        sync_q1 <= src_gray_q;  // May go metastable
        sync_q2 <= sync_q1;
    end
end

// Each binary bit is the XOR of all Gray bits at and above it
always_comb begin
    for (int i = 0; i < PW; i++) begin
        dst_ptr_o[i] = ^(sync_q2 >> i);
    end
end

endmodule

//--- hdl/fifo_wr_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write side of the FIFO, counted in write words
// rd_ptr_i must already be synchronized to wr_clk_i
// Full and free are pessimistic while the read pointer
// is still in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module fifo_wr_ctrl (
    input  logic                              wr_clk_i,
    input  logic                              wr_rst_n_i,

    input  logic                              wr_en_i,
    input  logic [fifo_dc_pkg::I_WIDTH-1:0]   wr_data_i,
    input  logic [fifo_dc_pkg::O_PW-1:0]      rd_ptr_i,

    output logic [fifo_dc_pkg::I_PW-1:0]      wr_ptr_o,
    output logic                              wr_full_o,
    output logic [fifo_dc_pkg::I_AW:0]        wr_free_o,

    fifo_ram_if.wr_mp                         ram
);

logic [fifo_dc_pkg::I_PW-1:0] wr_ptr_q;
logic [fifo_dc_pkg::I_PW-1:0] rd_ptr_w;
logic [fifo_dc_pkg::I_PW-1:0] wr_used;
logic                         wr_accept;

// A half-read entry still counts as occupied
assign rd_ptr_w = rd_ptr_i[fifo_dc_pkg::O_PW-1:fifo_dc_pkg::O_PW-fifo_dc_pkg::I_PW];

assign wr_full_o = (wr_ptr_q == {~rd_ptr_w[fifo_dc_pkg::I_PW-1],
                                 rd_ptr_w[fifo_dc_pkg::I_PW-2:0]});

assign wr_used   = wr_ptr_q - rd_ptr_w;  // Wraps correctly modulo two depths
assign wr_free_o = fifo_dc_pkg::I_DEPTH[fifo_dc_pkg::I_AW:0] - wr_used;

assign wr_accept = wr_en_i & ~wr_full_o;

always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
    if (!wr_rst_n_i) begin
        wr_ptr_q <= '0;
    end else if (wr_accept) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
    end
end

assign wr_ptr_o = wr_ptr_q;

assign ram.wr_en   = wr_accept;
assign ram.wr_addr = wr_ptr_q[fifo_dc_pkg::I_AW-1:0];
assign ram.wr_data = wr_data_i;

endmodule

//--- hdl/fifo_rd_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read side of the FIFO, counted in read words
// wr_ptr_i must already be synchronized to rd_clk_i
// Each write word becomes available as RATIO read words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module fifo_rd_ctrl (
    input  logic                              rd_clk_i,
    input  logic                              rd_rst_n_i,

    input  logic                              rd_en_i,
    input  logic [fifo_dc_pkg::I_PW-1:0]      wr_ptr_i,

    output logic [fifo_dc_pkg::O_PW-1:0]      rd_ptr_o,
    output logic                              rd_empty_o,
    output logic [fifo_dc_pkg::O_AW:0]        rd_avail_o,

    fifo_ram_if.rd_mp                         ram
);

logic [fifo_dc_pkg::O_PW-1:0] rd_ptr_q;
logic [fifo_dc_pkg::O_PW-1:0] wr_ptr_r;
logic                         rd_accept;

// Write pointer scaled up to read words
assign wr_ptr_r = {wr_ptr_i, {(fifo_dc_pkg::O_PW - fifo_dc_pkg::I_PW){1'b0}}};

assign rd_empty_o = (rd_ptr_q == wr_ptr_r);
assign rd_avail_o = wr_ptr_r - rd_ptr_q;

assign rd_accept = rd_en_i & ~rd_empty_o;

always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
    if (!rd_rst_n_i) begin
        rd_ptr_q <= '0;
    end else if (rd_accept) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
end

assign rd_ptr_o = rd_ptr_q;

// The RAM captures the word on the same edge that advances the pointer
assign ram.rd_en   = rd_accept;
assign ram.rd_addr = rd_ptr_q[fifo_dc_pkg::O_AW-1:0];

endmodule

//--- hdl/ram_tp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-port RAM, wide write port and narrow read port
// Read data is registered and holds between reads
// No read-during-write protection; the FIFO pointers keep
// the two ports on different entries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module ram_tp (
    input  logic       wr_clk_i,
    input  logic       rd_clk_i,

    fifo_ram_if.ram_mp ram
);

logic [fifo_dc_pkg::I_WIDTH-1:0] mem [fifo_dc_pkg::I_DEPTH];

logic [fifo_dc_pkg::I_AW-1:0]             rd_entry;
logic [$clog2(fifo_dc_pkg::RATIO)-1:0]    rd_lane;

// Upper read address bits pick the entry, the low bits pick the lane
assign rd_entry = ram.rd_addr[fifo_dc_pkg::O_AW-1:$clog2(fifo_dc_pkg::RATIO)];
assign rd_lane  = ram.rd_addr[$clog2(fifo_dc_pkg::RATIO)-1:0];

always_ff @(posedge wr_clk_i) begin
    if (ram.wr_en) begin
        mem[ram.wr_addr] <= ram.wr_data;
    end
end

always_ff @(posedge rd_clk_i) begin
    if (ram.rd_en) begin
        ram.rd_data <= mem[rd_entry][rd_lane*fifo_dc_pkg::O_WIDTH +: fifo_dc_pkg::O_WIDTH];
    end
end

endmodule

//--- hdl/fifo_dc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-clock FIFO, 32-bit words in and 16-bit words out
// Writes while full and reads while empty are ignored
// rd_data_o follows an accepted read by one rd_clk_i cycle
// Each reset clears its own domain only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module fifo_dc (
    input  logic                              wr_clk_i,
    input  logic                              wr_rst_n_i,

    input  logic                              wr_en_i,
    input  logic [fifo_dc_pkg::I_WIDTH-1:0]   wr_data_i,
    output logic                              wr_full_o,
    output logic [fifo_dc_pkg::I_AW:0]        wr_free_o,

    input  logic                              rd_clk_i,
    input  logic                              rd_rst_n_i,

    input  logic                              rd_en_i,
    output logic [fifo_dc_pkg::O_WIDTH-1:0]   rd_data_o,
    output logic                              rd_empty_o,
    output logic [fifo_dc_pkg::O_AW:0]        rd_avail_o
);

logic [fifo_dc_pkg::I_PW-1:0] wr_ptr;       // Write domain
logic [fifo_dc_pkg::I_PW-1:0] wr_ptr_sync;  // Read domain
logic [fifo_dc_pkg::O_PW-1:0] rd_ptr;       // Read domain
logic [fifo_dc_pkg::O_PW-1:0] rd_ptr_sync;  // Write domain

fifo_ram_if ram_if ();

fifo_wr_ctrl wr_ctrl_i (
    .wr_clk_i   (wr_clk_i),
    .wr_rst_n_i (wr_rst_n_i),
    .wr_en_i    (wr_en_i),
    .wr_data_i  (wr_data_i),
    .rd_ptr_i   (rd_ptr_sync),
    .wr_ptr_o   (wr_ptr),
    .wr_full_o  (wr_full_o),
    .wr_free_o  (wr_free_o),
    .ram        (ram_if.wr_mp)
);

fifo_rd_ctrl rd_ctrl_i (
    .rd_clk_i   (rd_clk_i),
    .rd_rst_n_i (rd_rst_n_i),
    .rd_en_i    (rd_en_i),
    .wr_ptr_i   (wr_ptr_sync),
    .rd_ptr_o   (rd_ptr),
    .rd_empty_o (rd_empty_o),
    .rd_avail_o (rd_avail_o),
    .ram        (ram_if.rd_mp)
);

ptr_cdc #(
    .PW (fifo_dc_pkg::I_PW)
) wr2rd (
    .src_clk_i   (wr_clk_i),
    .src_rst_n_i (wr_rst_n_i),
    .src_ptr_i   (wr_ptr),
    .dst_clk_i   (rd_clk_i),
    .dst_rst_n_i (rd_rst_n_i),
    .dst_ptr_o   (wr_ptr_sync)
);

ptr_cdc #(
    .PW (fifo_dc_pkg::O_PW)
) rd2wr (
    .src_clk_i   (rd_clk_i),
    .src_rst_n_i (rd_rst_n_i),
    .src_ptr_i   (rd_ptr),
    .dst_clk_i   (wr_clk_i),
    .dst_rst_n_i (wr_rst_n_i),
    .dst_ptr_o   (rd_ptr_sync)
);

ram_tp ram_i (
    .wr_clk_i (wr_clk_i),
    .rd_clk_i (rd_clk_i),
    .ram      (ram_if.ram_mp)
);

assign rd_data_o = ram_if.rd_data;

endmodule

//--- tb/fifo_dc_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions on the fifo_dc ports, bound into the top level
// Each check runs in the clock domain of the signals it covers
// assert_errs counts failures for the testbench summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module fifo_dc_properties (
    input logic                             wr_clk_i,
    input logic                             wr_rst_n_i,
    input logic                             wr_full_i,
    input logic [fifo_dc_pkg::I_AW:0]       wr_free_i,
    input logic                             rd_clk_i,
    input logic                             rd_rst_n_i,
    input logic                             rd_en_i,
    input logic [fifo_dc_pkg::O_WIDTH-1:0]  rd_data_i,
    input logic                             rd_empty_i,
    input logic [fifo_dc_pkg::O_AW:0]       rd_avail_i
);

int   assert_errs = 0;
logic rd_accept;

assign rd_accept = rd_en_i && !rd_empty_i;

full_matches_free_a : assert property (@(posedge wr_clk_i) disable iff (!wr_rst_n_i)
    wr_full_i == (wr_free_i == 0)) else begin
    $error("wr_full_o disagrees with the write-side free count");
    assert_errs++;
end

empty_matches_avail_a : assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
    rd_empty_i == (rd_avail_i == 0)) else begin
    $error("rd_empty_o disagrees with the read-side available count");
    assert_errs++;
end

// Data holds between accepted reads, X included
data_stable_a : assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
    !rd_accept |=> rd_data_i === $past(rd_data_i)) else begin
    $error("rd_data_o changed without an accepted read");
    assert_errs++;
end

free_in_range_a : assert property (@(posedge wr_clk_i) disable iff (!wr_rst_n_i)
    wr_free_i <= fifo_dc_pkg::I_DEPTH) else begin
    $error("wr_free_o is above the write-side depth");
    assert_errs++;
end

avail_in_range_a : assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
    rd_avail_i <= fifo_dc_pkg::O_DEPTH) else begin
    $error("rd_avail_o is above the read-side depth");
    assert_errs++;
end

endmodule

//--- tb/fifo_dc_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scoreboard for fifo_dc, fed from the DUT ports only
// Each accepted write queues its two halves, lower first
// Counts are totals since reset, so compare_counts is valid
// only once both clock domains are at rest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module fifo_dc_checker (
    input  logic                              wr_clk_i,
    input  logic                              wr_rst_n_i,
    input  logic                              wr_en_i,
    input  logic [fifo_dc_pkg::I_WIDTH-1:0]   wr_data_i,
    input  logic                              wr_full_i,
    input  logic [fifo_dc_pkg::I_AW:0]        wr_free_i,
    input  logic                              rd_clk_i,
    input  logic                              rd_rst_n_i,
    input  logic                              rd_en_i,
    input  logic [fifo_dc_pkg::O_WIDTH-1:0]   rd_data_i,
    input  logic                              rd_empty_i,
    input  logic [fifo_dc_pkg::O_AW:0]        rd_avail_i,
    output int                                err_cnt_o
);

logic [fifo_dc_pkg::O_WIDTH-1:0] model_q [$];
logic [fifo_dc_pkg::O_WIDTH-1:0] pend_data;
logic                            pend_valid = 1'b0;
int                              wr_cnt = 0;
int                              rd_cnt = 0;
string                           test_name = "none";

initial err_cnt_o = 0;

task automatic start_test(input string name);
    test_name = name;
endtask

task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("error %0s: %0s expected %0h, actual %0h", test_name, what, exp, act);
        err_cnt_o++;
    end
endtask

// Every write adds two read words and every second read frees a write word
task automatic compare_counts();
    check_value("rd_avail_o", 2 * wr_cnt - rd_cnt, rd_avail_i);
    check_value("wr_free_o", 16 - wr_cnt + rd_cnt / 2, wr_free_i);
endtask

always @(posedge wr_clk_i) begin
    if (wr_rst_n_i && wr_en_i && !wr_full_i) begin
        model_q.push_back(wr_data_i[fifo_dc_pkg::O_WIDTH-1:0]);
        model_q.push_back(wr_data_i[fifo_dc_pkg::I_WIDTH-1:fifo_dc_pkg::O_WIDTH]);
        wr_cnt++;
    end
end

always @(posedge rd_clk_i) begin
    if (pend_valid) begin
        check_value("rd_data_o", pend_data, rd_data_i);  // Registered one read cycle ago
    end
    pend_valid = 1'b0;
    if (rd_rst_n_i && !rd_empty_i && model_q.size() == 0) begin
        $display("%0s: rd_empty_o is low although every written word was read", test_name);
        err_cnt_o++;
    end
    if (rd_rst_n_i && rd_en_i && !rd_empty_i) begin
        if (model_q.size() != 0) begin
            pend_data  = model_q.pop_front();
            pend_valid = 1'b1;
        end
        rd_cnt++;
    end
end

endmodule

//--- tb/fifo_dc_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the dual-clock width-converting FIFO
// Write data and random enables come from a 16-bit LFSR
// Inputs change 2 ns after the rising edge of their clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module fifo_dc_tb;

localparam int RAND_CYCLES    = 300;
// Reset, reset state, order, full, counts, random, in read clock cycles
localparam int PLAN_CYCLES    = 4 + 15 + 55 + 85 + 40 + 470;
localparam int TIMEOUT_CYCLES = 2 * PLAN_CYCLES;

logic                            wr_clk;
logic                            wr_rst_n;
logic                            wr_en;
logic [fifo_dc_pkg::I_WIDTH-1:0] wr_data;
logic                            wr_full;
logic [fifo_dc_pkg::I_AW:0]      wr_free;
logic                            rd_clk;
logic                            rd_rst_n;
logic                            rd_en;
logic [fifo_dc_pkg::O_WIDTH-1:0] rd_data;
logic                            rd_empty;
logic [fifo_dc_pkg::O_AW:0]      rd_avail;

logic [15:0] lfsr_q;
int          chk_errs;
int          cycle_cnt = 0;
int          err_base = 0;
int          tests_passed = 0;
int          tests_failed = 0;
string       cur_test;

always #10 rd_clk = ~rd_clk;
always #13 wr_clk = ~wr_clk;  // Unrelated to rd_clk on purpose

fifo_dc dut_i (
    .wr_clk_i (wr_clk),   .wr_rst_n_i (wr_rst_n), .wr_en_i    (wr_en),
    .wr_data_i (wr_data), .wr_full_o  (wr_full),  .wr_free_o  (wr_free),
    .rd_clk_i (rd_clk),   .rd_rst_n_i (rd_rst_n), .rd_en_i    (rd_en),
    .rd_data_o (rd_data), .rd_empty_o (rd_empty), .rd_avail_o (rd_avail)
);

fifo_dc_checker chk_i (
    .wr_clk_i (wr_clk),   .wr_rst_n_i (wr_rst_n), .wr_en_i    (wr_en),
    .wr_data_i (wr_data), .wr_full_i  (wr_full),  .wr_free_i  (wr_free),
    .rd_clk_i (rd_clk),   .rd_rst_n_i (rd_rst_n), .rd_en_i    (rd_en),
    .rd_data_i (rd_data), .rd_empty_i (rd_empty), .rd_avail_i (rd_avail),
    .err_cnt_o (chk_errs)
);

bind fifo_dc fifo_dc_properties props_i (
    .wr_clk_i (wr_clk_i),   .wr_rst_n_i (wr_rst_n_i), .wr_full_i  (wr_full_o),
    .wr_free_i (wr_free_o), .rd_clk_i   (rd_clk_i),   .rd_rst_n_i (rd_rst_n_i),
    .rd_en_i (rd_en_i),     .rd_data_i  (rd_data_o),  .rd_empty_i (rd_empty_o),
    .rd_avail_i (rd_avail_o)
);

// Taps 16, 14, 13 and 11; the new bit is also the bit taken
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        r      = {r[30:0], fb};
    end
    return r;
endfunction

function automatic int total_errors();
    return chk_errs + dut_i.props_i.assert_errs;
endfunction

task automatic settle();
    fork
        repeat (6) @(posedge wr_clk);
        repeat (6) @(posedge rd_clk);
    join
endtask

task automatic begin_test(input string name);
    cur_test = name;
    chk_i.start_test(name);
    err_base = total_errors();
endtask

task automatic end_test();
    int errs;
    settle();
    errs = total_errors() - err_base;
    if (errs == 0) begin
        tests_passed++;
        $display("Test %0s passed", cur_test);
    end else begin
        tests_failed++;
        $display("Test %0s failed with %0d errors", cur_test, errs);
    end
endtask

// Holds each word until it is accepted, optionally giving up at full
task automatic write_words(input int max_n, input bit stop_at_full, output int n);
    bit stop;
    n    = 0;
    stop = 1'b0;
    @(posedge wr_clk);
    #2;
    wr_en   = 1'b1;
    wr_data = lfsr_bits(32);
    while (n < max_n && !stop) begin
        @(posedge wr_clk);
        if (!wr_full) begin
            n++;
            #2;
            wr_data = lfsr_bits(32);
        end else begin
            stop = stop_at_full;
            #2;
        end
    end
    wr_en = 1'b0;
endtask

task automatic read_words(input int max_n, input bit stop_at_empty, output int n);
    bit stop;
    n    = 0;
    stop = 1'b0;
    @(posedge rd_clk);
    #2;
    rd_en = 1'b1;
    while (n < max_n && !stop) begin
        @(posedge rd_clk);
        if (!rd_empty) begin
            n++;
        end else begin
            stop = stop_at_empty;
        end
        #2;
    end
    rd_en = 1'b0;
endtask

// Starts on a rising rd_clk edge and issues three reads into an empty FIFO
task automatic idle_reads();
    #2;
    rd_en = 1'b1;
    repeat (3) @(posedge rd_clk);
    #2;
    rd_en = 1'b0;
    @(posedge rd_clk);
endtask

task automatic wait_not_empty();
    @(posedge rd_clk);
    while (rd_empty) @(posedge rd_clk);
endtask

task automatic test_reset_state();
    begin_test("reset_state");
    @(posedge rd_clk);
    chk_i.check_value("rd_empty_o", 1, rd_empty);
    chk_i.check_value("wr_full_o", 0, wr_full);
    chk_i.check_value("wr_free_o", 16, wr_free);
    chk_i.check_value("rd_avail_o", 0, rd_avail);
    idle_reads();
    chk_i.check_value("rd_empty_o", 1, rd_empty);
    chk_i.check_value("rd_avail_o", 0, rd_avail);
    end_test();
endtask

task automatic test_order();
    logic [fifo_dc_pkg::O_WIDTH-1:0] held;
    int                              n;
    begin_test("order");
    write_words(8, 1'b0, n);
    wait_not_empty();
    read_words(16, 1'b0, n);
    @(posedge rd_clk);
    chk_i.check_value("rd_empty_o", 1, rd_empty);
    held = rd_data;  // Last upper half, a known value
    idle_reads();
    chk_i.check_value("rd_data_o", held, rd_data);
    chk_i.check_value("rd_empty_o", 1, rd_empty);
    end_test();
endtask

task automatic test_full();
    int n;
    begin_test("full");
    write_words(32, 1'b1, n);
    chk_i.check_value("accepted writes", 16, n);
    chk_i.check_value("wr_free_o", 0, wr_free);
    wr_en = 1'b1;  // These writes must all be dropped
    repeat (3) @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
    @(posedge rd_clk);
    while (rd_avail != 32) @(posedge rd_clk);
    read_words(64, 1'b1, n);
    chk_i.check_value("words drained", 32, n);
    end_test();
endtask

task automatic test_counts();
    int n;
    begin_test("counts");
    write_words(5, 1'b0, n);
    wait_not_empty();
    read_words(3, 1'b0, n);
    settle();
    chk_i.compare_counts();
    end_test();
endtask

task automatic test_random();
    logic [RAND_CYCLES-1:0]          wr_en_pat;
    logic [RAND_CYCLES-1:0]          rd_en_pat;
    logic [fifo_dc_pkg::I_WIDTH-1:0] data_pat [RAND_CYCLES];
    logic [31:0]                     r;
    int                              n;
    begin_test("random");
    for (int i = 0; i < RAND_CYCLES; i++) begin
        r            = lfsr_bits(2);
        wr_en_pat[i] = r[1];
        rd_en_pat[i] = r[0];
        data_pat[i]  = lfsr_bits(32);
    end
    fork
        begin
            for (int i = 0; i < RAND_CYCLES; i++) begin
                @(posedge wr_clk);
                #2;
                wr_en   = wr_en_pat[i];
                wr_data = data_pat[i];
            end
            @(posedge wr_clk);
            #2;
            wr_en = 1'b0;
        end
        begin
            for (int i = 0; i < RAND_CYCLES; i++) begin
                @(posedge rd_clk);
                #2;
                rd_en = rd_en_pat[i];
            end
            @(posedge rd_clk);
            #2;
            rd_en = 1'b0;
        end
    join
    settle();
    read_words(64, 1'b1, n);
    settle();
    chk_i.check_value("rd_empty_o", 1, rd_empty);
    chk_i.compare_counts();
    end_test();
endtask

always @(posedge rd_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("Run stopped after %0d read clock cycles, the test hung", cycle_cnt);
        $display("Verification failed");
        $finish;
    end
end

initial begin
    wr_clk   = 1'b0;
    rd_clk   = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    lfsr_q   = 16'd41909;
    repeat (4) @(posedge rd_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    test_reset_state();
    test_order();
    test_full();
    test_counts();
    test_random();
    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

endmodule

//--- src.f
hdl/fifo_dc_pkg.sv
hdl/fifo_ram_if.sv
hdl/ptr_cdc.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/ram_tp.sv
hdl/fifo_dc.sv
tb/fifo_dc_properties.sv
tb/fifo_dc_checker.sv
tb/fifo_dc_tb.sv
